//--- video_pkg.sv
//==============================
// Video types, pixel and scan structs,
// DVI control symbols and flag colours
//==============================
`default_nettype none

package video_pkg;

    typedef logic [11:0] coord_t;     // Screen position on either axis
    typedef logic [7:0]  colour_t;    // One colour channel
    typedef logic [9:0]  tmds_sym_t;  // One encoded TMDS character

    // Timing generator output, one screen position per clock
    typedef struct packed {
        coord_t sx;     // Column, counts through blanking too
        coord_t sy;     // Row
        logic   hsync;  // Positive polarity
        logic   vsync;  // Positive polarity
        logic   de;     // Inside the active picture
    } scan_t;

    // Painted pixel with its sync, aligned to the same clock
    typedef struct packed {
        colour_t r;
        colour_t g;
        colour_t b;
        logic    hsync;
        logic    vsync;
        logic    de;
    } pixel_t;

    // DVI control characters, indexed by {c1, c0}
    localparam tmds_sym_t CTRL_00 = 10'b1101010100;
    localparam tmds_sym_t CTRL_01 = 10'b0010101011;
    localparam tmds_sym_t CTRL_10 = 10'b0101010100;
    localparam tmds_sym_t CTRL_11 = 10'b1010101011;

    // Flag colours as {r, g, b}
    // 4-bit source values with each nibble doubled up to 8 bits
    localparam logic [23:0] COL_BLUE   = {8'h00, 8'h66, 8'hAA};
    localparam logic [23:0] COL_YELLOW = {8'hFF, 8'hCC, 8'h00};
    localparam logic [23:0] COL_BLACK  = {8'h00, 8'h00, 8'h00};

endpackage

`default_nettype wire

//--- display_timing.sv
//==============================
// Display timing generator
// Screen counters, sync and data enable
//==============================
`default_nettype none
`timescale 1ns/1ps

module display_timing #(
    parameter int H_ACTIVE = 1280,  // Visible columns
    parameter int H_FRONT  = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BACK   = 220,
    parameter int V_ACTIVE = 720,   // Visible rows
    parameter int V_FRONT  = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BACK   = 20
) (
    input  wire logic             clk_pix,
    input  wire logic             rst_n,
    output      video_pkg::scan_t scan
);
    import video_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam coord_t H_LAST   = coord_t'(H_TOTAL - 1);     // Last column of a line
    localparam coord_t V_LAST   = coord_t'(V_TOTAL - 1);     // Last row of a frame
    localparam coord_t H_VIS    = coord_t'(H_ACTIVE);
    localparam coord_t V_VIS    = coord_t'(V_ACTIVE);
    localparam coord_t HS_START = coord_t'(H_ACTIVE + H_FRONT);
    localparam coord_t HS_END   = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam coord_t VS_START = coord_t'(V_ACTIVE + V_FRONT);
    localparam coord_t VS_END   = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

    coord_t sx_next;  // Position one clock ahead
    coord_t sy_next;

    // Step the column, wrap into the next row and frame
    always_comb begin
        sx_next = scan.sx + 1'b1;
        sy_next = scan.sy;
        if (scan.sx == H_LAST) begin
            sx_next = '0;
            sy_next = (scan.sy == V_LAST) ? '0 : scan.sy + 1'b1;
        end
    end

    // Flags come from the next position so they land in the same register as it
    // Reset parks on the last pixel of the frame, so the first clock out of
    // reset presents the origin
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            scan.sx    <= H_LAST;
            scan.sy    <= V_LAST;
            scan.hsync <= 1'b0;
            scan.vsync <= 1'b0;
            scan.de    <= 1'b0;
        end else begin
            scan.sx    <= sx_next;
            scan.sy    <= sy_next;
            scan.hsync <= (sx_next >= HS_START) && (sx_next < HS_END);
            scan.vsync <= (sy_next >= VS_START) && (sy_next < VS_END);
            scan.de    <= (sx_next < H_VIS) && (sy_next < V_VIS);
        end
    end

    // Counters never leave the frame
    a_scan_range: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (scan.sx <= H_LAST) && (scan.sy <= V_LAST))
        else $error("scan position outside frame");

endmodule

`default_nettype wire

//--- flag_painter.sv
//==============================
// Flag of Sweden painter
// Colour lookup and registered pixel stage
//==============================
`default_nettype none
`timescale 1ns/1ps

module flag_painter #(
    parameter int FLAG_W = 640,  // Flag width in pixels, 16:10 ratio
    parameter int FLAG_H = 400   // Flag height in pixels
) (
    input  wire logic              clk_pix,
    input  wire logic              rst_n,
    input  wire video_pkg::scan_t  scan,
    output      video_pkg::pixel_t pixel
);
    import video_pkg::*;

    // Cross bands, edges exclusive
    localparam coord_t FLAG_BOTTOM = coord_t'(FLAG_H);
    localparam coord_t CROSS_Y_LO  = coord_t'(FLAG_H * 4 / 10);  // Horizontal bar top
    localparam coord_t CROSS_Y_HI  = coord_t'(FLAG_H * 6 / 10);  // Horizontal bar bottom
    localparam coord_t CROSS_X_LO  = coord_t'(FLAG_W * 5 / 16);  // Vertical bar left
    localparam coord_t CROSS_X_HI  = coord_t'(FLAG_W * 7 / 16);  // Vertical bar right

    logic [23:0] paint;   // Colour for the current scan position, {r, g, b}
    logic [23:0] rgb_q;
    logic        hsync_q;
    logic        vsync_q;
    logic        de_q;

    always_comb begin
        if (!scan.de || scan.sy >= FLAG_BOTTOM) begin
            paint = COL_BLACK;                      // Blanking or below the flag
        end else if (scan.sy > CROSS_Y_LO && scan.sy < CROSS_Y_HI) begin
            paint = COL_YELLOW;                     // Horizontal bar of the cross
        end else if (scan.sx > CROSS_X_LO && scan.sx < CROSS_X_HI) begin
            paint = COL_YELLOW;                     // Vertical bar
        end else begin
            paint = COL_BLUE;                       // Field
        end
    end

    // Sync and enable ride one clock behind the scan, like the colour
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
            de_q    <= 1'b0;
        end else begin
            hsync_q <= scan.hsync;
            vsync_q <= scan.vsync;
            de_q    <= scan.de;
        end
    end

    always_ff @(posedge clk_pix) begin
        rgb_q <= paint;  // Colour payload
    end

    assign pixel = {rgb_q, hsync_q, vsync_q, de_q};

    // Encoders see pure black whenever the picture is blanked
    a_blank_black: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !pixel.de |-> (pixel.r == '0) && (pixel.g == '0) && (pixel.b == '0))
        else $error("colour present during blanking");

endmodule

`default_nettype wire

//--- tmds_encoder.sv
//==============================
// DVI TMDS encoder, one channel
// Transition minimising, DC balanced
//==============================
`default_nettype none
`timescale 1ns/1ps

module tmds_encoder (
    input  wire logic                 clk_pix,
    input  wire logic                 rst_n,
    input  wire video_pkg::colour_t   data,  // Colour, used while de is high
    input  wire logic [1:0]           ctrl,  // {c1, c0}, used while de is low
    input  wire logic                 de,
    output      video_pkg::tmds_sym_t sym
);
    import video_pkg::*;

    logic [3:0]        data_ones;  // Ones in the input byte
    logic              use_xnor;   // Stage 1 chaining choice
    logic [8:0]        q_m;        // Stage 1 result, bit 8 set for XOR
    logic [3:0]        qm_ones;
    logic signed [5:0] qm_bal;     // Ones minus zeros in q_m[7:0]
    logic signed [5:0] qm8_x2;     // 2 * q_m[8]
    logic signed [5:0] cnt;        // Running disparity, ones minus zeros
    logic signed [5:0] cnt_next;
    tmds_sym_t         sym_next;

    // XOR or XNOR each bit with the previous result
    function automatic logic [8:0] chain(input colour_t d, input logic xnor_mode);
        logic [8:0] q;
        q[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            q[i] = xnor_mode ? ~(q[i-1] ^ d[i]) : (q[i-1] ^ d[i]);
        end
        q[8] = ~xnor_mode;
        return q;
    endfunction

    // Stage 1, fewer transitions
    assign data_ones = 4'($countones(data));
    assign use_xnor  = (data_ones > 4'd4) || (data_ones == 4'd4 && !data[0]);
    assign q_m       = chain(data, use_xnor);

    assign qm_ones = 4'($countones(q_m[7:0]));
    assign qm_bal  = $signed({1'b0, qm_ones, 1'b0}) - 6'sd8;  // 2*ones - 8
    assign qm8_x2  = $signed({4'b0000, q_m[8], 1'b0});

    // Stage 2, pick polarity to pull the disparity toward zero
    always_comb begin
        if (!de) begin
            cnt_next = '0;  // Control period restarts the balance
            case (ctrl)
                2'b00:   sym_next = CTRL_00;
                2'b01:   sym_next = CTRL_01;
                2'b10:   sym_next = CTRL_10;
                default: sym_next = CTRL_11;
            endcase
        end else if (cnt == 0 || qm_bal == 0) begin
            // Balanced case, bit 9 is the inverse of bit 8
            sym_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            cnt_next = q_m[8] ? cnt + qm_bal : cnt - qm_bal;
        end else if ((!cnt[5] && qm_bal > 0) || (cnt[5] && qm_bal < 0)) begin
            // Same sign as the running count, invert
            sym_next = {1'b1, q_m[8], ~q_m[7:0]};
            cnt_next = cnt + qm8_x2 - qm_bal;
        end else begin
            sym_next = {1'b0, q_m[8], q_m[7:0]};  // Send as is
            cnt_next = cnt - (6'sd2 - qm8_x2) + qm_bal;
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sym <= CTRL_00;  // Blank with no sync until the first pixel arrives
            cnt <= '0;
        end else begin
            sym <= sym_next;
            cnt <= cnt_next;
        end
    end

    // Balance bound of the DVI encoding across a whole data period
    a_disparity_bound: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (cnt >= -16) && (cnt <= 16))
        else $error("TMDS disparity out of range");

endmodule

`default_nettype wire

//--- flag_display_top.sv
//==============================
// Flag display top level
// Timing, painter and TMDS encoders
//==============================
`default_nettype none
`timescale 1ns/1ps

module flag_display_top #(
    parameter int H_ACTIVE = 1280,  // 720p60 by default
    parameter int H_FRONT  = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BACK   = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT  = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BACK   = 20,
    parameter int FLAG_W   = 640,   // Flag drawn from the top left corner
    parameter int FLAG_H   = 400
) (
    input  wire logic                 clk_pix,
    input  wire logic                 rst_n,
    output      video_pkg::tmds_sym_t tmds_ch0,  // Blue plus syncs
    output      video_pkg::tmds_sym_t tmds_ch1,  // Green
    output      video_pkg::tmds_sym_t tmds_ch2   // Red
);
    import video_pkg::*;

    scan_t  scan;   // Screen position and raw sync
    pixel_t pixel;  // Painted colour, one clock later

    display_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_display_timing (
        .clk_pix,
        .rst_n,
        .scan
    );

    flag_painter #(
        .FLAG_W(FLAG_W),
        .FLAG_H(FLAG_H)
    ) u_flag_painter (
        .clk_pix,
        .rst_n,
        .scan,
        .pixel
    );

    // Channel 0 carries the syncs in its control period
    tmds_encoder u_enc_b (
        .clk_pix,
        .rst_n,
        .data (pixel.b),
        .ctrl ({pixel.vsync, pixel.hsync}),
        .de   (pixel.de),
        .sym  (tmds_ch0)
    );

    tmds_encoder u_enc_g (
        .clk_pix,
        .rst_n,
        .data (pixel.g),
        .ctrl (2'b00),      // No control data on green
        .de   (pixel.de),
        .sym  (tmds_ch1)
    );

    tmds_encoder u_enc_r (
        .clk_pix,
        .rst_n,
        .data (pixel.r),
        .ctrl (2'b00),
        .de   (pixel.de),
        .sym  (tmds_ch2)
    );

endmodule

`default_nettype wire

//--- tb_flag_display.sv
//==============================
// Flag display testbench
// TMDS decoding, scan tracker, checks
//==============================
`default_nettype none
`timescale 1ns/1ps

module tb_flag_display;

    // Tiny screen so a few frames run fast
    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BACK   = 8;
    localparam int V_ACTIVE = 40;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 4;
    localparam int FLAG_W   = 64;
    localparam int FLAG_H   = 30;

    localparam int H_TOTAL        = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL        = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAMES         = 3;
    localparam int TIMEOUT_CYCLES = (FRAMES + 2) * H_TOTAL * V_TOTAL;
    localparam int FILL_CYCLES    = 3;  // Scan, pixel and symbol registers

    // DVI control characters, {c1, c0}
    localparam logic [9:0] CTL_00 = 10'b1101010100;
    localparam logic [9:0] CTL_01 = 10'b0010101011;
    localparam logic [9:0] CTL_10 = 10'b0101010100;
    localparam logic [9:0] CTL_11 = 10'b1010101011;

    // Flag colours {r, g, b}
    localparam logic [23:0] RGB_BLUE   = 24'h0066AA;
    localparam logic [23:0] RGB_YELLOW = 24'hFFCC00;
    localparam logic [23:0] RGB_BLACK  = 24'h000000;

    logic       clk_pix;
    logic       rst_n;
    logic [9:0] tmds_ch0;  // Blue with syncs
    logic [9:0] tmds_ch1;  // Green
    logic [9:0] tmds_ch2;  // Red

    // Decoded view of the current symbols
    logic        ch0_ctrl;
    logic        is_data;
    logic        hs_now;
    logic        vs_now;
    logic        hs_rise;
    logic        hs_fall;
    logic        vs_rise;
    logic        vs_fall;
    int          col_now;
    int          row_now;
    logic [23:0] rgb_now;
    int          disp_now [3];

    // Tracker state
    logic hs_q;
    logic vs_q;
    logic line_armed;    // Next data symbol opens a line
    logic frame_armed;   // Next line opens a frame
    logic hs_seen;
    logic fall_seen;
    logic red_inv_seen;
    logic red_plain_seen;
    int   col_q;
    int   row_q;
    int   hs_len;        // Cycles of hsync so far
    int   vs_len;
    int   line_len;      // Cycles since the last hsync rise
    int   porch_len;     // Cycles since the last hsync fall
    int   post_rst;
    int   frames;
    int   disp_q [3];

    flag_display_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .FLAG_W(FLAG_W), .FLAG_H(FLAG_H)
    ) u_flag_display_top (
        .clk_pix,
        .rst_n,
        .tmds_ch0,
        .tmds_ch1,
        .tmds_ch2
    );

    function automatic logic is_control_sym(input logic [9:0] s);
        return (s == CTL_00) || (s == CTL_01) || (s == CTL_10) || (s == CTL_11);
    endfunction

    // Undo the polarity flip, then the XOR or XNOR chain
    function automatic logic [7:0] decode_sym(input logic [9:0] s);
        logic [7:0] q;
        logic [7:0] d;
        int         i;
        q    = s[9] ? ~s[7:0] : s[7:0];
        d[0] = q[0];
        for (i = 1; i < 8; i++) begin
            d[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);  // Bit 8 set means XOR
        end
        return d;
    endfunction

    // Ones minus zeros over a whole symbol
    function automatic int sym_balance(input logic [9:0] s);
        int ones;
        int i;
        ones = 0;
        for (i = 0; i < 10; i++) begin
            ones += int'(s[i]);
        end
        return 2 * ones - 10;
    endfunction

    function automatic logic within_bound(input int v);
        return (v >= -16) && (v <= 16);
    endfunction

    // Swedish flag, cross edges exclusive
    function automatic logic [23:0] flag_colour(input int x, input int y);
        logic [23:0] c;
        if (y >= FLAG_H) begin
            c = RGB_BLACK;                                  // Below the flag
        end else if (y > FLAG_H * 4 / 10 && y < FLAG_H * 6 / 10) begin
            c = RGB_YELLOW;
        end else if (x > FLAG_W * 5 / 16 && x < FLAG_W * 7 / 16) begin
            c = RGB_YELLOW;
        end else begin
            c = RGB_BLUE;
        end
        return c;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    always_comb begin
        ch0_ctrl = is_control_sym(tmds_ch0);
        is_data  = !ch0_ctrl;
        hs_now   = (tmds_ch0 == CTL_01) || (tmds_ch0 == CTL_11);
        vs_now   = (tmds_ch0 == CTL_10) || (tmds_ch0 == CTL_11);
        hs_rise  = hs_now && !hs_q;
        hs_fall  = !hs_now && hs_q;
        vs_rise  = vs_now && !vs_q;
        vs_fall  = !vs_now && vs_q;
        col_now  = line_armed ? 0 : col_q + 1;
        row_now  = row_q;
        if (is_data && line_armed) begin
            row_now = frame_armed ? 0 : row_q + 1;  // New line of data
        end
        rgb_now     = {decode_sym(tmds_ch2), decode_sym(tmds_ch1), decode_sym(tmds_ch0)};
        disp_now[0] = is_data ? disp_q[0] + sym_balance(tmds_ch0) : 0;
        disp_now[1] = is_data ? disp_q[1] + sym_balance(tmds_ch1) : 0;
        disp_now[2] = is_data ? disp_q[2] + sym_balance(tmds_ch2) : 0;
    end

    // Scan tracker, rebuilt from the symbol stream alone
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            hs_q           <= 1'b0;
            vs_q           <= 1'b0;
            line_armed     <= 1'b1;  // Stream leaves reset at the origin
            frame_armed    <= 1'b1;
            hs_seen        <= 1'b0;
            fall_seen      <= 1'b0;
            red_inv_seen   <= 1'b0;
            red_plain_seen <= 1'b0;
            col_q          <= 0;
            row_q          <= 0;
            hs_len         <= 0;
            vs_len         <= 0;
            line_len       <= 0;
            porch_len      <= 0;
            post_rst       <= 0;
            frames         <= 0;
            disp_q         <= '{0, 0, 0};
        end else begin
            hs_q      <= hs_now;
            vs_q      <= vs_now;
            col_q     <= col_now;
            row_q     <= row_now;
            hs_len    <= hs_now ? hs_len + 1 : 0;
            vs_len    <= vs_now ? vs_len + 1 : 0;
            line_len  <= hs_rise ? 1 : line_len + 1;
            porch_len <= hs_fall ? 1 : porch_len + 1;
            disp_q    <= disp_now;
            if (post_rst < FILL_CYCLES) begin
                post_rst <= post_rst + 1;
            end
            if (is_data) begin
                line_armed  <= 1'b0;
                frame_armed <= 1'b0;
                if (tmds_ch2[9]) begin
                    red_inv_seen <= 1'b1;
                end else begin
                    red_plain_seen <= 1'b1;
                end
            end
            if (hs_rise) begin
                hs_seen <= 1'b1;
            end
            if (hs_fall) begin
                line_armed <= 1'b1;
                fall_seen  <= 1'b1;
            end
            if (vs_fall) begin
                frame_armed <= 1'b1;
            end
            if (vs_rise) begin
                frames         <= frames + 1;  // One frame per vsync
                red_inv_seen   <= 1'b0;
                red_plain_seen <= 1'b0;
            end
        end
    end

    a_ctrl_symbols: assert property (@(posedge clk_pix) disable iff (!rst_n)
        ch0_ctrl ? (tmds_ch1 == CTL_00 && tmds_ch2 == CTL_00)
                 : (!is_control_sym(tmds_ch1) && !is_control_sym(tmds_ch2)))
        else abort_run($sformatf("[ERROR] %0t: channels disagree, %b %b %b", $time,
            $sampled(tmds_ch0), $sampled(tmds_ch1), $sampled(tmds_ch2)));

    // Pipeline fill and blanking before the first hsync
    a_reset_blank: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (post_rst < FILL_CYCLES) || (!hs_seen && ch0_ctrl && !hs_now) |->
        (tmds_ch0 == CTL_00) && (tmds_ch1 == CTL_00) && (tmds_ch2 == CTL_00))
        else abort_run($sformatf("[ERROR] %0t: expected blank control after reset", $time));

    a_hsync_width: assert property (@(posedge clk_pix) disable iff (!rst_n)
        hs_fall |-> hs_len == H_SYNC)
        else abort_run($sformatf("[ERROR] %0t: hsync lasted %0d cycles", $time,
            $sampled(hs_len)));

    a_line_period: assert property (@(posedge clk_pix) disable iff (!rst_n)
        hs_rise && hs_seen |-> line_len == H_TOTAL)
        else abort_run($sformatf("[ERROR] %0t: line period %0d", $time, $sampled(line_len)));

    a_back_porch: assert property (@(posedge clk_pix) disable iff (!rst_n)
        is_data && line_armed && fall_seen |-> porch_len == H_BACK)
        else abort_run($sformatf("[ERROR] %0t: back porch %0d", $time, $sampled(porch_len)));

    a_vsync_width: assert property (@(posedge clk_pix) disable iff (!rst_n)
        vs_fall |-> vs_len == V_SYNC * H_TOTAL)
        else abort_run($sformatf("[ERROR] %0t: vsync lasted %0d cycles", $time,
            $sampled(vs_len)));

    // H_ACTIVE data symbols in one unbroken run
    a_data_window: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !line_armed |-> is_data == (col_now < H_ACTIVE))
        else abort_run($sformatf("[ERROR] %0t: data window wrong at column %0d", $time,
            $sampled(col_now)));

    a_row_range: assert property (@(posedge clk_pix) disable iff (!rst_n)
        is_data && line_armed |-> row_now < V_ACTIVE)
        else abort_run($sformatf("[ERROR] %0t: data on row %0d", $time, $sampled(row_now)));

    a_frame_rows: assert property (@(posedge clk_pix) disable iff (!rst_n)
        vs_rise |-> row_q == V_ACTIVE - 1)
        else abort_run($sformatf("[ERROR] %0t: frame ended after row %0d", $time,
            $sampled(row_q)));

    a_pixel_colour: assert property (@(posedge clk_pix) disable iff (!rst_n)
        is_data |-> rgb_now == flag_colour(col_now, row_now))
        else abort_run($sformatf("[ERROR] %0t: pixel (%0d,%0d) is %h, expected %h", $time,
            $sampled(col_now), $sampled(row_now), $sampled(rgb_now),
            flag_colour($sampled(col_now), $sampled(row_now))));

    a_disparity: assert property (@(posedge clk_pix) disable iff (!rst_n)
        is_data |-> within_bound(disp_now[0]) && within_bound(disp_now[1]) &&
        within_bound(disp_now[2]))
        else abort_run($sformatf("[ERROR] %0t: disparity %0d %0d %0d", $time,
            $sampled(disp_now[0]), $sampled(disp_now[1]), $sampled(disp_now[2])));

    // Red toggles polarity on the blue field
    a_red_polarity: assert property (@(posedge clk_pix) disable iff (!rst_n)
        vs_rise |-> red_inv_seen && red_plain_seen)
        else abort_run($sformatf("[ERROR] %0t: red used one polarity only", $time));

    initial begin
        clk_pix = 1'b0;
        forever #4 clk_pix = ~clk_pix;  // 125 MHz
    end

    initial begin
        int cycles;
        rst_n  = 1'b0;
        cycles = 0;
        repeat (3) @(posedge clk_pix);
        rst_n <= 1'b1;
        while (frames < FRAMES && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_pix);
            cycles++;
        end
        if (frames < FRAMES) begin
            abort_run($sformatf("Timeout after %0d cycles, only %0d frames seen",
                cycles, frames));
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
video_pkg.sv
display_timing.sv
flag_painter.sv
tmds_encoder.sv
flag_display_top.sv
tb_flag_display.sv

//--- Makefile
# Verilator build for the flag display

VERILATOR  ?= verilator
FILELIST   := tb.f
TB_TOP     := tb_flag_display
RTL_TOP    := flag_display_top
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --assert -j 0
BUILD_DIR  := obj_dir
PASS_TEXT  := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

# Pass only when the testbench printed its pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -F "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
